// ==== dv/ctrlChecker.sv ====
/*
 * Control output checker
 * Compares the DUT control outputs with the expected row on each strobe
 */

module ctrlChecker (
    input  logic        clk,
    input  logic        checkEn,
    input  int          rowIdx,
    input  logic [20:0] expBits,
    input  logic [20:0] dutOut,
    output int          checks,
    output int          rowErrors,
    output int          bitErrors
);
    timeunit 1ns;
    timeprecision 100ps;

    // Output names, MSB of the packed vector first
    string names [21] = '{
        "preifWr", "ifWr", "idWr", "exeWr", "memWr", "mem2Wr", "wbWr",
        "ifFlush", "idFlush", "exeFlush", "memFlush", "mem2Flush", "wbFlush",
        "idDisWr", "exeDisWr", "memDisWr", "wbDisWr",
        "iReqValid", "dReqValid", "iCacheStall", "dCacheStall"
    };

    int checkCount = 0;
    int rowCount   = 0;
    int bitCount   = 0;

    assign checks    = checkCount;
    assign rowErrors = rowCount;
    assign bitErrors = bitCount;

    // Outputs settled since the falling edge drive
    always @(posedge clk) begin
        if (checkEn) begin
            checkCount++;
            if (dutOut !== expBits) begin
                rowCount++;
                for (int i = 20; i >= 0; i--) begin
                    if (dutOut[i] !== expBits[i]) begin
                        bitCount++;
                        $display("ERR %0d ns: row %0d %s is %b, expected %b",
                                 $time, rowIdx, names[20-i], dutOut[i], expBits[i]);
                    end
                end
            end
        end
    end

endmodule

// ==== dv/hazardCtrlTb.sv ====
/*
 * Hazard control testbench
 * Applies a table of stimulus rows on the falling edge and hands the
 * expected control outputs to the checker at the next rising edge
 */

`include "pipeCtrl_consts.svh"

module hazardCtrlTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuRegPkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int RESET_LIMIT = 20;
    localparam int RUN_LIMIT   = 200;

    // Control bits {mulDivStart, exc, branch, jump, iTlb, dTlb, icache, dcache}
    localparam logic [7:0] C_MDS  = 8'h80;
    localparam logic [7:0] C_EXC  = 8'h40;
    localparam logic [7:0] C_BR   = 8'h20;
    localparam logic [7:0] C_JMP  = 8'h10;
    localparam logic [7:0] C_ITLB = 8'h08;
    localparam logic [7:0] C_DTLB = 8'h04;
    localparam logic [7:0] C_ICB  = 8'h02;
    localparam logic [7:0] C_DCB  = 8'h01;

    // Expected rows as {Wr[7], Flush[6], DisWr[4], iReq, dReq, iStall, dStall}
    localparam logic [20:0] ROW_NORMAL     = {7'b1111111, 6'b000000, 4'b0000, 4'b1100};
    localparam logic [20:0] ROW_FREEZE     = {7'b0000000, 6'b000000, 4'b0011, 4'b1111};
    localparam logic [20:0] ROW_FREEZE_EXC = {7'b0000000, 6'b000000, 4'b0111, 4'b0011};
    localparam logic [20:0] ROW_MULDIV     = {7'b0000000, 6'b000000, 4'b0111, 4'b1111};
    localparam logic [20:0] ROW_EXC        = {7'b1000011, 6'b111100, 4'b0110, 4'b0000};
    localparam logic [20:0] ROW_HAZ_MEM2   = {7'b0000011, 6'b000010, 4'b0010, 4'b0110};
    localparam logic [20:0] ROW_HAZ_MEM1   = {7'b0000111, 6'b000100, 4'b0100, 4'b0110};
    localparam logic [20:0] ROW_HAZ_EX     = {7'b0001111, 6'b001000, 4'b1000, 4'b0110};
    localparam logic [20:0] ROW_BRANCH     = {7'b1001111, 6'b110000, 4'b0000, 4'b0100};
    localparam logic [20:0] ROW_JUMP       = {7'b1011111, 6'b100000, 4'b0000, 4'b0100};

    // Load destinations below the filler range
    localparam regIdxT EX_D = 5'd5;
    localparam regIdxT M1_D = 5'd6;
    localparam regIdxT M2_D = 5'd7;

    typedef struct packed {
        logic [7:0]  ctrl;
        logic [1:0]  uses;     // {usesRs, usesRt}
        regIdxT      rs;
        regIdxT      rt;
        logic [2:0]  loads;    // {ex, mem1, mem2}
        regIdxT      exD;
        regIdxT      m1D;
        regIdxT      m2D;
        logic [20:0] want;
    } stimRowT;

    logic clk, reset;
    logic iTlbStall, dTlbStall, icacheBusy, dcacheBusy, mulDivStart;
    logic flushException, branchFailed, idIsImmeJump;
    regIdxT idRs, idRt, exDest, mem1Dest, mem2Dest;
    logic idUsesRs, idUsesRt, exIsLoad, mem1IsLoad, mem2IsLoad;
    logic preifWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr;
    logic ifFlush, idFlush, exeFlush, memFlush, mem2Flush, wbFlush;
    logic idDisWr, exeDisWr, memDisWr, wbDisWr;
    logic iReqValid, dReqValid, iCacheStall, dCacheStall;

    logic [20:0] dutOut;
    logic [20:0] expBits;
    logic        checkEn;
    logic        runDone;
    int          rowIdx;
    int          checks, rowErrors, bitErrors;
    stimRowT     rows[$];
    logic [15:0] lfsr = 16'd48536;

    assign dutOut = {preifWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr,
                     ifFlush, idFlush, exeFlush, memFlush, mem2Flush, wbFlush,
                     idDisWr, exeDisWr, memDisWr, wbDisWr,
                     iReqValid, dReqValid, iCacheStall, dCacheStall};

    tbClock clkGen (.clk(clk), .reset(reset));

    hazardCtrlTop dut (.*);

    ctrlChecker outChecker (
        .clk(clk), .checkEn(checkEn), .rowIdx(rowIdx), .expBits(expBits),
        .dutOut(dutOut), .checks(checks), .rowErrors(rowErrors), .bitErrors(bitErrors)
    );

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Random index in 16..31 with one LFSR step per bit
    function automatic regIdxT fillerReg();
        regIdxT r;
        r = regIdxT'(16);
        for (int b = 0; b < 4; b++) begin
            lfsr = lfsrNext(lfsr);
            r[b] = lfsr[0];
        end
        return r;
    endfunction

    task automatic addRow(input logic [7:0] ctrl, input logic [1:0] uses,
                          input regIdxT rs, input regIdxT rt, input logic [2:0] loads,
                          input regIdxT exD, input regIdxT m1D, input regIdxT m2D,
                          input logic [20:0] want);
        rows.push_back('{ctrl, uses, rs, rt, loads, exD, m1D, m2D, want});
    endtask

    // Both sources random and every stage a load that never matches
    task automatic addIdle(input logic [7:0] ctrl, input logic [20:0] want);
        regIdxT a;
        regIdxT b;
        a = fillerReg();
        b = fillerReg();
        addRow(ctrl, 2'b11, a, b, 3'b111, EX_D, M1_D, M2_D, want);
    endtask

    task automatic addHazard(input logic [7:0] ctrl, input logic [1:0] uses,
                             input regIdxT rs, input regIdxT rt, input logic [2:0] loads,
                             input logic [20:0] want);
        addRow(ctrl, uses, rs, rt, loads, EX_D, M1_D, M2_D, want);
    endtask

    task automatic buildTable();
        addIdle(8'h00, ROW_NORMAL);
        // Single conflicts and a matching non-load
        addHazard(8'h00, 2'b11, EX_D, fillerReg(), 3'b111, ROW_HAZ_EX);
        addHazard(8'h00, 2'b11, fillerReg(), M1_D, 3'b111, ROW_HAZ_MEM1);
        addHazard(8'h00, 2'b01, fillerReg(), M2_D, 3'b001, ROW_HAZ_MEM2);
        addHazard(8'h00, 2'b11, EX_D, fillerReg(), 3'b011, ROW_NORMAL);
        // Oldest load wins
        addHazard(8'h00, 2'b11, EX_D, M2_D, 3'b111, ROW_HAZ_MEM2);
        addHazard(8'h00, 2'b11, EX_D, M1_D, 3'b111, ROW_HAZ_MEM1);
        addRow(8'h00, 2'b10, 5'd8, fillerReg(), 3'b111, 5'd8, 5'd8, 5'd8, ROW_HAZ_MEM2);
        // r0 and unused sources
        addRow(8'h00, 2'b11, 5'd0, fillerReg(), 3'b111, 5'd0, 5'd0, 5'd0, ROW_NORMAL);
        addHazard(8'h00, 2'b01, EX_D, fillerReg(), 3'b111, ROW_NORMAL);
        addHazard(8'h00, 2'b10, fillerReg(), M1_D, 3'b111, ROW_NORMAL);
        addHazard(8'h00, 2'b00, EX_D, M2_D, 3'b111, ROW_NORMAL);
        // Redirects alone and mixed with hazards
        addIdle(C_EXC, ROW_EXC);
        addIdle(C_BR, ROW_BRANCH);
        addIdle(C_JMP, ROW_JUMP);
        addIdle(C_BR | C_JMP, ROW_BRANCH);
        addHazard(C_EXC, 2'b11, EX_D, fillerReg(), 3'b111, ROW_EXC);
        addHazard(C_EXC, 2'b11, M2_D, M1_D, 3'b111, ROW_EXC);
        addHazard(C_BR, 2'b11, EX_D, fillerReg(), 3'b111, ROW_HAZ_EX);
        addHazard(C_JMP, 2'b01, fillerReg(), M1_D, 3'b111, ROW_HAZ_MEM1);
        // Memory side busy held over two rows for the D cache
        addIdle(C_DCB, ROW_FREEZE);
        addIdle(C_DCB, ROW_FREEZE);
        addIdle(C_DTLB, ROW_FREEZE);
        addIdle(C_ICB, ROW_FREEZE);
        addIdle(C_ITLB, ROW_FREEZE);
        addIdle(C_DCB | C_EXC, ROW_FREEZE_EXC);
        addIdle(C_ITLB | C_EXC, ROW_FREEZE_EXC);
        // Start row still normal before the busy window
        addIdle(C_MDS, ROW_NORMAL);
        for (int n = 0; n < `MULDIV_CYCLES; n++) begin
            addIdle(8'h00, ROW_MULDIV);
        end
        addIdle(8'h00, ROW_NORMAL);
    endtask

    task automatic applyRow(input int i);
        stimRowT r;
        r = rows[i];
        {mulDivStart, flushException, branchFailed, idIsImmeJump,
         iTlbStall, dTlbStall, icacheBusy, dcacheBusy} = r.ctrl;
        {idUsesRs, idUsesRt} = r.uses;
        idRs = r.rs;
        idRt = r.rt;
        {exIsLoad, mem1IsLoad, mem2IsLoad} = r.loads;
        exDest = r.exD;
        mem1Dest = r.m1D;
        mem2Dest = r.m2D;
        expBits = r.want;
        rowIdx = i;
        checkEn = 1'b1;
    endtask

    initial begin : stimulus
        int waited;
        {mulDivStart, flushException, branchFailed, idIsImmeJump} = '0;
        {iTlbStall, dTlbStall, icacheBusy, dcacheBusy} = '0;
        {idUsesRs, idUsesRt, exIsLoad, mem1IsLoad, mem2IsLoad} = '0;
        {idRs, idRt, exDest, mem1Dest, mem2Dest} = '0;
        expBits = '0;
        checkEn = 1'b0;
        rowIdx = 0;
        runDone = 1'b0;
        buildTable();
        waited = 0;
        while (reset !== 1'b0 && waited < RESET_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (reset !== 1'b0) begin
            $display("Reset still asserted after %0d clock cycles", RESET_LIMIT);
            $display("test failed");
        end else begin
            for (int i = 0; i < rows.size(); i++) begin
                applyRow(i);
                @(negedge clk);
            end
            checkEn = 1'b0;
            runDone = 1'b1;
            $display("Rows checked %0d of %0d, rows wrong %0d, bits wrong %0d",
                     checks, rows.size(), rowErrors, bitErrors);
            if (rowErrors == 0 && checks == rows.size()) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
        end
        $finish;
    end

    // Guards the whole run against a stalled stimulus loop
    initial begin : watchdog
        int periods;
        periods = 0;
        while (runDone !== 1'b1 && periods < RUN_LIMIT) begin
            #(CLK_PERIOD);
            periods++;
        end
        if (runDone !== 1'b1) begin
            $display("Timeout, stimulus did not finish within %0d clock periods", RUN_LIMIT);
            $display("test failed");
            $finish;
        end
    end

endmodule

// ==== dv/tbClock.sv ====
/*
 * Testbench clock and reset
 * 100 ns clock, synchronous reset held over the first rising edges
 */

module tbClock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the hazard control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module hazardCtrlTb \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== src.f ====
+incdir+verilog
verilog/cpuRegPkg.sv
verilog/pipeCtrlPkg.sv
verilog/dataHazardUnit.sv
verilog/stallTracker.sv
verilog/pipelineControl.sv
verilog/hazardCtrlTop.sv
dv/tbClock.sv
dv/ctrlChecker.sv
dv/hazardCtrlTb.sv

// ==== verilog/cpuRegPkg.sv ====
/*
 * CPU register package
 * Architectural register index type and zero register test
 */

`include "pipeCtrl_consts.svh"

package cpuRegPkg;

    // Index width follows the register file size
    localparam int GPR_IDX_W = $clog2(`NUM_GPR);

    // One general purpose register index
    typedef logic [GPR_IDX_W-1:0] regIdxT;

    // True for the hardwired zero register
    function automatic logic regIsZero(input regIdxT idx);
        return idx == regIdxT'(`REG_ZERO);
    endfunction

endpackage

// ==== verilog/dataHazardUnit.sv ====
/*
 * Data hazard unit
 * Finds load-use conflicts between the ID sources and the loads in
 * EXE, MEM and MEM2, reporting the most urgent stage
 */

module dataHazardUnit (
    input  cpuRegPkg::regIdxT     idRs,
    input  cpuRegPkg::regIdxT     idRt,
    input  logic                  idUsesRs,
    input  logic                  idUsesRt,
    input  cpuRegPkg::regIdxT     exDest,
    input  cpuRegPkg::regIdxT     mem1Dest,
    input  cpuRegPkg::regIdxT     mem2Dest,
    input  logic                  exIsLoad,
    input  logic                  mem1IsLoad,
    input  logic                  mem2IsLoad,
    output pipeCtrlPkg::hazardSrcT hazardSrc
);

    import cpuRegPkg::*;
    import pipeCtrlPkg::*;

    // One ID source against one destination
    // Unused sources and r0 never conflict
    function automatic logic srcHits(input regIdxT src, input logic used,
                                     input regIdxT dest);
        return used && !regIsZero(src) && (src == dest);
    endfunction

    logic exHit;
    logic mem1Hit;
    logic mem2Hit;

    // A stage only matters while it carries a load
    assign exHit   = exIsLoad &&
                     (srcHits(idRs, idUsesRs, exDest) || srcHits(idRt, idUsesRt, exDest));
    assign mem1Hit = mem1IsLoad &&
                     (srcHits(idRs, idUsesRs, mem1Dest) || srcHits(idRt, idUsesRt, mem1Dest));
    assign mem2Hit = mem2IsLoad &&
                     (srcHits(idRs, idUsesRs, mem2Dest) || srcHits(idRt, idUsesRt, mem2Dest));

    always_comb begin
        // Oldest load wins as it must drain first
        if (mem2Hit) begin
            hazardSrc = mem2;
        end else if (mem1Hit) begin
            hazardSrc = mem1;
        end else if (exHit) begin
            hazardSrc = ex;
        end else begin
            hazardSrc = none;
        end
    end

endmodule

// ==== verilog/hazardCtrlTop.sv ====
/*
 * Hazard control top
 * Hazard detection and stall tracking side by side, merged by
 * the pipeline control priority logic
 */

module hazardCtrlTop (
    input  logic              clk,
    input  logic              reset,
    input  logic              iTlbStall,
    input  logic              dTlbStall,
    input  logic              icacheBusy,
    input  logic              dcacheBusy,
    input  logic              mulDivStart,
    input  logic              flushException,
    input  logic              branchFailed,
    input  logic              idIsImmeJump,
    input  cpuRegPkg::regIdxT idRs,
    input  cpuRegPkg::regIdxT idRt,
    input  logic              idUsesRs,
    input  logic              idUsesRt,
    input  cpuRegPkg::regIdxT exDest,
    input  cpuRegPkg::regIdxT mem1Dest,
    input  cpuRegPkg::regIdxT mem2Dest,
    input  logic              exIsLoad,
    input  logic              mem1IsLoad,
    input  logic              mem2IsLoad,
    output logic              preifWr,
    output logic              ifWr,
    output logic              idWr,
    output logic              exeWr,
    output logic              memWr,
    output logic              mem2Wr,
    output logic              wbWr,
    output logic              ifFlush,
    output logic              idFlush,
    output logic              exeFlush,
    output logic              memFlush,
    output logic              mem2Flush,
    output logic              wbFlush,
    output logic              idDisWr,
    output logic              exeDisWr,
    output logic              memDisWr,
    output logic              wbDisWr,
    output logic              iReqValid,
    output logic              dReqValid,
    output logic              iCacheStall,
    output logic              dCacheStall
);

    import pipeCtrlPkg::*;

    hazardSrcT hazardSrc;
    logic      dMemStall;
    logic      iMemStall;
    logic      mulDivBusy;

    // Load-use detection, combinational
    dataHazardUnit uHazard (
        .idRs       (idRs),
        .idRt       (idRt),
        .idUsesRs   (idUsesRs),
        .idUsesRt   (idUsesRt),
        .exDest     (exDest),
        .mem1Dest   (mem1Dest),
        .mem2Dest   (mem2Dest),
        .exIsLoad   (exIsLoad),
        .mem1IsLoad (mem1IsLoad),
        .mem2IsLoad (mem2IsLoad),
        .hazardSrc  (hazardSrc)
    );

    // Memory busy merge and mul/div window
    stallTracker uStall (
        .clk         (clk),
        .reset       (reset),
        .iTlbStall   (iTlbStall),
        .dTlbStall   (dTlbStall),
        .icacheBusy  (icacheBusy),
        .dcacheBusy  (dcacheBusy),
        .mulDivStart (mulDivStart),
        .dMemStall   (dMemStall),
        .iMemStall   (iMemStall),
        .mulDivBusy  (mulDivBusy)
    );

    // Priority row selection
    pipelineControl uCtrl (
        .flushException (flushException),
        .branchFailed   (branchFailed),
        .idIsImmeJump   (idIsImmeJump),
        .hazardSrc      (hazardSrc),
        .dMemStall      (dMemStall),
        .iMemStall      (iMemStall),
        .mulDivBusy     (mulDivBusy),
        .preifWr        (preifWr),
        .ifWr           (ifWr),
        .idWr           (idWr),
        .exeWr          (exeWr),
        .memWr          (memWr),
        .mem2Wr         (mem2Wr),
        .wbWr           (wbWr),
        .ifFlush        (ifFlush),
        .idFlush        (idFlush),
        .exeFlush       (exeFlush),
        .memFlush       (memFlush),
        .mem2Flush      (mem2Flush),
        .wbFlush        (wbFlush),
        .idDisWr        (idDisWr),
        .exeDisWr       (exeDisWr),
        .memDisWr       (memDisWr),
        .wbDisWr        (wbDisWr),
        .iReqValid      (iReqValid),
        .dReqValid      (dReqValid),
        .iCacheStall    (iCacheStall),
        .dCacheStall    (dCacheStall)
    );

endmodule

// ==== verilog/pipeCtrlPkg.sv ====
/*
 * Pipeline hazard package
 * Names the stage that holds a conflicting load
 */

package pipeCtrlPkg;

    // Stage holding the load that ID depends on
    typedef enum logic [1:0] {
        none = 2'd0,    // no load-use conflict
        ex   = 2'd1,    // load still in EXE
        mem1 = 2'd2,    // load in first memory stage
        mem2 = 2'd3     // load in second memory stage
    } hazardSrcT;

    // Any load-use conflict at all
    function automatic logic isHazard(input hazardSrcT src);
        return src != none;
    endfunction

endpackage

// ==== verilog/pipeCtrl_consts.svh ====
/*
 * Pipeline control constants
 * Register file geometry and multiply/divide latency
 */

`ifndef PIPECTRL_CONSTS_SVH
`define PIPECTRL_CONSTS_SVH

// General purpose registers in the architectural file
`define NUM_GPR 32

// Hardwired zero register, never a hazard source
`define REG_ZERO 0

// Busy cycles of the mul/div unit after one start
`define MULDIV_CYCLES 4

`endif

// ==== verilog/pipelineControl.sv ====
/*
 * Pipeline control
 * Picks one control row by fixed priority and drives stage write
 * enables, flushes, write disables and cache request controls
 */

module pipelineControl (
    input  logic                   flushException,
    input  logic                   branchFailed,
    input  logic                   idIsImmeJump,
    input  pipeCtrlPkg::hazardSrcT hazardSrc,
    input  logic                   dMemStall,
    input  logic                   iMemStall,
    input  logic                   mulDivBusy,
    output logic                   preifWr,
    output logic                   ifWr,
    output logic                   idWr,
    output logic                   exeWr,
    output logic                   memWr,
    output logic                   mem2Wr,
    output logic                   wbWr,
    output logic                   ifFlush,
    output logic                   idFlush,
    output logic                   exeFlush,
    output logic                   memFlush,
    output logic                   mem2Flush,
    output logic                   wbFlush,
    output logic                   idDisWr,
    output logic                   exeDisWr,
    output logic                   memDisWr,
    output logic                   wbDisWr,
    output logic                   iReqValid,
    output logic                   dReqValid,
    output logic                   iCacheStall,
    output logic                   dCacheStall
);

    import pipeCtrlPkg::*;

    always_comb begin
        // Normal row where everything advances
        preifWr     = 1'b1;
        ifWr        = 1'b1;
        idWr        = 1'b1;
        exeWr       = 1'b1;
        memWr       = 1'b1;
        mem2Wr      = 1'b1;
        wbWr        = 1'b1;
        ifFlush     = 1'b0;
        idFlush     = 1'b0;
        exeFlush    = 1'b0;
        memFlush    = 1'b0;
        mem2Flush   = 1'b0;
        wbFlush     = 1'b0;
        idDisWr     = 1'b0;
        memDisWr    = 1'b0;
        wbDisWr     = 1'b0;
        iCacheStall = 1'b0;
        dCacheStall = 1'b0;

        // D side, I side and mul/div share the same freeze row
        if (dMemStall || iMemStall || mulDivBusy) begin
            {preifWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr} = '0;
            memDisWr    = 1'b1;
            wbDisWr     = 1'b1;
            iCacheStall = 1'b1;
            dCacheStall = 1'b1;
        end else if (flushException) begin
            // Redirect to handler and drop IF through MEM
            {ifWr, idWr, exeWr, memWr}             = '0;
            {ifFlush, idFlush, exeFlush, memFlush} = '1;
            memDisWr = 1'b1;
        end else if (hazardSrc == mem2) begin
            // Only MEM2 and WB move with a bubble into MEM2
            {preifWr, ifWr, idWr, exeWr, memWr} = '0;
            mem2Flush   = 1'b1;
            memDisWr    = 1'b1;
            iCacheStall = 1'b1;
        end else if (hazardSrc == mem1) begin
            // Bubble into MEM
            {preifWr, ifWr, idWr, exeWr} = '0;
            memFlush    = 1'b1;
            iCacheStall = 1'b1;
        end else if (hazardSrc == ex) begin
            // Bubble into EXE while ID holds
            {preifWr, ifWr, idWr} = '0;
            exeFlush    = 1'b1;
            idDisWr     = 1'b1;
            iCacheStall = 1'b1;
        end else if (branchFailed) begin
            // Wrong path in IF and ID
            ifWr    = 1'b0;
            idWr    = 1'b0;
            ifFlush = 1'b1;
            idFlush = 1'b1;
        end else if (idIsImmeJump) begin
            // One slot in IF to discard
            ifWr    = 1'b0;
            ifFlush = 1'b1;
        end
    end

    // HILO write guard independent of the row
    assign exeDisWr = flushException || (hazardSrc == mem1) || mulDivBusy;

    // No new fetch while the front end is redirected or held
    assign iReqValid = !(flushException || isHazard(hazardSrc) ||
                         branchFailed || idIsImmeJump);

    // Data requests are only dropped on an exception
    assign dReqValid = !flushException;

endmodule

// ==== verilog/stallTracker.sv ====
/*
 * Stall tracker
 * Merges cache and TLB busy sources per side and counts down
 * the multiply/divide busy window
 */

`include "pipeCtrl_consts.svh"

module stallTracker (
    input  logic clk,
    input  logic reset,
    input  logic iTlbStall,
    input  logic dTlbStall,
    input  logic icacheBusy,
    input  logic dcacheBusy,
    input  logic mulDivStart,
    output logic dMemStall,
    output logic iMemStall,
    output logic mulDivBusy
);

    // Wide enough to hold the full busy count
    localparam int CNT_W = $clog2(`MULDIV_CYCLES + 1);

    logic [CNT_W-1:0] mulDivCnt;

    // Either a TLB miss or a cache miss holds its side
    assign dMemStall = dTlbStall || dcacheBusy;
    assign iMemStall = iTlbStall || icacheBusy;

    // Busy while cycles remain
    assign mulDivBusy = (mulDivCnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            mulDivCnt <= '0;
        end else if (mulDivStart && !mulDivBusy) begin
            // Load the full window on a fresh start
            mulDivCnt <= CNT_W'(`MULDIV_CYCLES);
        end else if (mulDivBusy) begin
            mulDivCnt <= mulDivCnt - 1'b1;
        end
    end

    // Issue logic must hold a second start until the unit is free
    assert property (@(posedge clk) disable iff (reset)
        mulDivStart |-> !mulDivBusy)
        else $error("mul/div start while unit busy");

endmodule
